/* include/cw_io_settings.svh */
`ifndef CW_IO_SETTINGS_SVH
`define CW_IO_SETTINGS_SVH

`define CW_NUM_IO           4      // Target IO channels

// Register map
`define CW_ADDR_CTRL        6'h00
`define CW_ADDR_TRIGCNT     6'h01
`define CW_ADDR_IO_BASE     6'h10  // Channel n at base + n

// Channel register fields
`define CW_IO_OE_BIT        0      // Output enable
`define CW_IO_VAL_BIT       1      // Drive value
`define CW_IO_TEN_BIT       2      // Trigger enable
`define CW_IO_INV_BIT       3      // Trigger invert
`define CW_IO_PIN_BIT       4      // Synced pin, read only

// Control register fields
`define CW_CTRL_AND_BIT     0      // 0 = OR, 1 = AND
`define CW_CTRL_PWROFF_BIT  1      // Target power off

`endif

/* rtl/cw_io_pkg.sv */
`default_nettype none

package cw_io_pkg;

   // Register bus address, same width as the board's register bus
   typedef logic [5:0] reg_addr_t;

   // Register bus data
   typedef logic [7:0] reg_data_t;

   // Host bridge FSM
   typedef enum logic [1:0] {
      IDLE,      // Waiting for host req
      ACCESS,    // Strobe issue and read capture
      ACK_HIGH   // Holding ack until req drops
   } bridge_state_t;

endpackage

`default_nettype wire

/* rtl/cw_io_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cw_io_settings.svh"

module cw_io_top (
   input  wire                  clk_usb,
   input  wire                  rst_n_i,

   // Host port
   input  wire                  host_req_i,
   input  wire                  host_write_i,
   input  wire cw_io_pkg::reg_addr_t host_addr_i,
   input  wire cw_io_pkg::reg_data_t host_wdata_i,
   output wire                  host_ack_o,
   output wire cw_io_pkg::reg_data_t host_rdata_o,

   inout  wire [`CW_NUM_IO-1:0] target_io_io,   // Target pins

   output wire                  trigger_o,
   output wire                  target_npower_o
);
   import cw_io_pkg::*;

   wire reg_addr_t reg_addr;
   wire reg_data_t reg_wdata;
   wire            reg_write;
   wire            reg_read;
   wire reg_data_t reg_rdata;   // Merged in the collector

   wire reg_data_t       chan_rdata [`CW_NUM_IO];
   wire [`CW_NUM_IO-1:0] trig_req;
   wire [`CW_NUM_IO-1:0] trig_en;
   wire                  target_highz;

   usb_reg_bridge i_usb_reg_bridge (
      .clk_usb      (clk_usb),
      .rst_n_i      (rst_n_i),
      .host_req_i   (host_req_i),
      .host_write_i (host_write_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_ack_o   (host_ack_o),
      .host_rdata_o (host_rdata_o),
      .reg_addr_o   (reg_addr),
      .reg_wdata_o  (reg_wdata),
      .reg_write_o  (reg_write),
      .reg_read_o   (reg_read),
      .reg_rdata_i  (reg_rdata)
   );

   genvar gi;
   generate
      for (gi = 0; gi < `CW_NUM_IO; gi++) begin : g_chan
         target_io_channel #(
            .CHAN_ADDR (reg_addr_t'(`CW_ADDR_IO_BASE + gi))
         ) i_target_io_channel (
            .clk_usb        (clk_usb),
            .rst_n_i        (rst_n_i),
            .reg_addr_i     (reg_addr),
            .reg_wdata_i    (reg_wdata),
            .reg_write_i    (reg_write),
            .reg_read_i     (reg_read),
            .reg_rdata_o    (chan_rdata[gi]),
            .target_highz_i (target_highz),
            .pin_io         (target_io_io[gi]),
            .trig_req_o     (trig_req[gi]),
            .trig_en_o      (trig_en[gi])
         );
      end
   endgenerate

   trigger_collector i_trigger_collector (
      .clk_usb         (clk_usb),
      .rst_n_i         (rst_n_i),
      .reg_addr_i      (reg_addr),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .reg_read_i      (reg_read),
      .chan_rdata_i    (chan_rdata),
      .trig_req_i      (trig_req),
      .trig_en_i       (trig_en),
      .reg_rdata_o     (reg_rdata),
      .target_highz_o  (target_highz),
      .target_npower_o (target_npower_o),
      .trigger_o       (trigger_o)
   );

endmodule

`default_nettype wire

/* rtl/target_io_channel.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cw_io_settings.svh"

module target_io_channel #(
   parameter cw_io_pkg::reg_addr_t CHAN_ADDR = `CW_ADDR_IO_BASE
) (
   input  wire                  clk_usb,
   input  wire                  rst_n_i,

   // Register bus
   input  wire cw_io_pkg::reg_addr_t reg_addr_i,
   input  wire cw_io_pkg::reg_data_t reg_wdata_i,
   input  wire                  reg_write_i,
   input  wire                  reg_read_i,
   output cw_io_pkg::reg_data_t reg_rdata_o,

   input  wire                  target_highz_i,   // Power off, float pin

   inout  wire                  pin_io,

   output logic                 trig_req_o,
   output logic                 trig_en_o
);
   import cw_io_pkg::*;

   logic [`CW_IO_INV_BIT:`CW_IO_OE_BIT] cfg_q;   // OE, VAL, TEN, INV
   logic [1:0] pin_sync_q;                        // Two-flop synchronizer
   logic       pin_s;
   logic       addr_hit;
   logic       drive_en;
   reg_data_t  readback;

   assign addr_hit = (reg_addr_i == CHAN_ADDR);

   always_ff @(posedge clk_usb or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_q <= '0;
      end else if (reg_write_i && addr_hit) begin
         cfg_q <= reg_wdata_i[`CW_IO_INV_BIT:`CW_IO_OE_BIT];   // PIN bit ignored
      end
   end

   // Pin driver
   assign drive_en = cfg_q[`CW_IO_OE_BIT] & ~target_highz_i;
   assign pin_io   = drive_en ? cfg_q[`CW_IO_VAL_BIT] : 1'bz;

   always_ff @(posedge clk_usb or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pin_sync_q <= 2'b00;
      end else begin
         pin_sync_q <= {pin_sync_q[0], pin_io};
      end
   end

   assign pin_s = pin_sync_q[1];

   // Trigger request
   assign trig_en_o  = cfg_q[`CW_IO_TEN_BIT];
   assign trig_req_o = cfg_q[`CW_IO_TEN_BIT] & (pin_s ^ cfg_q[`CW_IO_INV_BIT]);

   always_comb begin
      readback = '0;
      readback[`CW_IO_INV_BIT:`CW_IO_OE_BIT] = cfg_q;
      readback[`CW_IO_PIN_BIT] = pin_s;
   end

   // Zero unless this channel is read, so the collector can OR
   assign reg_rdata_o = (reg_read_i && addr_hit) ? readback : '0;

endmodule

`default_nettype wire

/* rtl/trigger_collector.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cw_io_settings.svh"

module trigger_collector (
   input  wire                  clk_usb,
   input  wire                  rst_n_i,

   // Register bus
   input  wire cw_io_pkg::reg_addr_t reg_addr_i,
   input  wire cw_io_pkg::reg_data_t reg_wdata_i,
   input  wire                  reg_write_i,
   input  wire                  reg_read_i,

   // From the channels
   input  wire cw_io_pkg::reg_data_t chan_rdata_i [`CW_NUM_IO],
   input  wire [`CW_NUM_IO-1:0] trig_req_i,
   input  wire [`CW_NUM_IO-1:0] trig_en_i,

   output cw_io_pkg::reg_data_t reg_rdata_o,
   output logic                 target_highz_o,
   output logic                 target_npower_o,
   output logic                 trigger_o
);
   import cw_io_pkg::*;

   logic [`CW_CTRL_PWROFF_BIT:`CW_CTRL_AND_BIT] ctrl_q;
   reg_data_t trig_cnt_q;       // Wraps at 256
   logic      trig_q;
   logic      trig_d_q;         // Previous trigger, edge detect
   logic      any_en;
   logic      all_req;
   logic      trig_comb;
   reg_data_t own_rdata;
   reg_data_t merged_rdata;

   always_ff @(posedge clk_usb or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (reg_write_i && reg_addr_i == `CW_ADDR_CTRL) begin
         ctrl_q <= reg_wdata_i[`CW_CTRL_PWROFF_BIT:`CW_CTRL_AND_BIT];
      end
   end

   // Disabled channels do not block the AND
   assign any_en  = |trig_en_i;
   assign all_req = &(trig_req_i | ~trig_en_i);

   assign trig_comb = ctrl_q[`CW_CTRL_AND_BIT] ? (any_en & all_req) : (|trig_req_i);

   always_ff @(posedge clk_usb or negedge rst_n_i) begin
      if (!rst_n_i) begin
         trig_q   <= 1'b0;
         trig_d_q <= 1'b0;
      end else begin
         trig_q   <= trig_comb;
         trig_d_q <= trig_q;
      end
   end

   always_ff @(posedge clk_usb or negedge rst_n_i) begin
      if (!rst_n_i) begin
         trig_cnt_q <= '0;
      end else if (reg_write_i && reg_addr_i == `CW_ADDR_TRIGCNT) begin
         trig_cnt_q <= '0;                  // Any write clears
      end else if (trig_q && !trig_d_q) begin
         trig_cnt_q <= trig_cnt_q + 1'b1;
      end
   end

   always_comb begin
      own_rdata = '0;
      if (reg_read_i) begin
         if (reg_addr_i == `CW_ADDR_CTRL) begin
            own_rdata[`CW_CTRL_PWROFF_BIT:`CW_CTRL_AND_BIT] = ctrl_q;
         end else if (reg_addr_i == `CW_ADDR_TRIGCNT) begin
            own_rdata = trig_cnt_q;
         end
      end
   end

   // Unmapped addresses fall out as zero
   always_comb begin
      merged_rdata = own_rdata;
      for (int i = 0; i < `CW_NUM_IO; i++) begin
         merged_rdata = merged_rdata | chan_rdata_i[i];
      end
   end

   assign reg_rdata_o     = merged_rdata;
   assign target_highz_o  = ctrl_q[`CW_CTRL_PWROFF_BIT];
   assign target_npower_o = ctrl_q[`CW_CTRL_PWROFF_BIT];
   assign trigger_o       = trig_q;

endmodule

`default_nettype wire

/* rtl/usb_reg_bridge.sv */
`default_nettype none
`timescale 1ns/1ps

module usb_reg_bridge (
   input  wire                  clk_usb,
   input  wire                  rst_n_i,

   // Host four-phase port
   input  wire                  host_req_i,
   input  wire                  host_write_i,
   input  wire cw_io_pkg::reg_addr_t host_addr_i,
   input  wire cw_io_pkg::reg_data_t host_wdata_i,
   output logic                 host_ack_o,
   output cw_io_pkg::reg_data_t host_rdata_o,

   // Register bus
   output cw_io_pkg::reg_addr_t reg_addr_o,
   output cw_io_pkg::reg_data_t reg_wdata_o,
   output logic                 reg_write_o,
   output logic                 reg_read_o,
   input  wire cw_io_pkg::reg_data_t reg_rdata_i
);
   import cw_io_pkg::*;

   bridge_state_t state_q;

   reg_addr_t addr_q;       // Latched request fields
   reg_data_t wdata_q;
   logic      write_q;

   logic      strobe_q;     // One cycle per handshake
   logic      req_q;        // Registered req for release detect
   logic      ack_q;
   reg_data_t rdata_q;

   // Request fields are taken once, when the FSM leaves IDLE
   always_ff @(posedge clk_usb) begin
      if (state_q == IDLE && host_req_i) begin
         addr_q  <= host_addr_i;
         wdata_q <= host_wdata_i;
         write_q <= host_write_i;
      end
   end

   always_ff @(posedge clk_usb or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         strobe_q <= 1'b0;
         req_q    <= 1'b0;
         ack_q    <= 1'b0;
         rdata_q  <= '0;
      end else begin
         req_q <= host_req_i;
         unique case (state_q)
            IDLE: begin
               if (host_req_i) begin
                  state_q <= ACCESS;
               end
            end
            ACCESS: begin
               if (!strobe_q) begin
                  strobe_q <= 1'b1;          // Bus strobe cycle
               end else begin
                  strobe_q <= 1'b0;
                  rdata_q  <= reg_rdata_i;   // End of strobe cycle
                  ack_q    <= 1'b1;
                  state_q  <= ACK_HIGH;
               end
            end
            ACK_HIGH: begin
               // Ack drops one edge after req is seen low
               if (!req_q) begin
                  ack_q   <= 1'b0;
                  state_q <= IDLE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   assign reg_addr_o   = addr_q;
   assign reg_wdata_o  = wdata_q;
   assign reg_write_o  = strobe_q & write_q;
   assign reg_read_o   = strobe_q & ~write_q;

   assign host_ack_o   = ack_q;
   assign host_rdata_o = rdata_q;   // Held with ack

endmodule

`default_nettype wire

/* src.f */
+incdir+include
rtl/cw_io_pkg.sv
rtl/usb_reg_bridge.sv
rtl/target_io_channel.sv
rtl/trigger_collector.sv
rtl/cw_io_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cw_io_top.sv

/* testbench/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   always begin
      #(PERIOD_NS / 2);   // Half period
      clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

/* testbench/tb_cw_io_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cw_io_settings.svh"

module tb_cw_io_top;
   import cw_io_pkg::*;

   localparam int TIMEOUT_CYCLES = 5000;   // About 2700 counter cycles and 900 others
   localparam int ACK_WAIT_LIMIT = 16;
   localparam int TOGGLE_COUNT   = 259;    // Wraps the 8-bit counter once
   localparam int TRIG_ROUNDS    = 16;

   wire                   clk;
   logic                  rst_n;
   logic                  host_req;
   logic                  host_wr;
   reg_addr_t             host_addr;
   reg_data_t             host_wdata;
   wire                   host_ack;
   wire reg_data_t        host_rdata;
   wire [`CW_NUM_IO-1:0]  pins;
   wire                   trigger;
   wire                   target_npower;
   logic [`CW_NUM_IO-1:0] drv_en;      // Testbench pin drivers
   logic [`CW_NUM_IO-1:0] drv_val;
   int                    seed = 89;
   int                    cycle_cnt = 0;

   genvar gi;
   generate
      for (gi = 0; gi < `CW_NUM_IO; gi++) begin : g_pin
         assign pins[gi] = drv_en[gi] ? drv_val[gi] : 1'bz;
         pulldown i_pulldown (pins[gi]);   // Floating pin reads 0
      end
   endgenerate

   tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clk_o(clk));

   cw_io_top i_cw_io_top (
      .clk_usb         (clk),
      .rst_n_i         (rst_n),
      .host_req_i      (host_req),
      .host_write_i    (host_wr),
      .host_addr_i     (host_addr),
      .host_wdata_i    (host_wdata),
      .host_ack_o      (host_ack),
      .host_rdata_o    (host_rdata),
      .target_io_io    (pins),
      .trigger_o       (trigger),
      .target_npower_o (target_npower)
   );

   task automatic check_equal(input string sig, input logic [31:0] act, input logic [31:0] exp_v);
      assert (act === exp_v) else begin
         $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, act);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   function automatic reg_addr_t chan_addr(input int idx);
      return reg_addr_t'(`CW_ADDR_IO_BASE + idx);
   endfunction

   // AND mode needs every enabled channel and at least one enabled
   function automatic logic trigger_rule(input logic and_mode, input logic [3:0] en,
                                         input logic [3:0] inv, input logic [3:0] pin);
      logic [3:0] req;
      req = en & (pin ^ inv);
      if (and_mode) begin
         return (en != 4'b0000) && ((req & en) == en);
      end else begin
         return req != 4'b0000;
      end
   endfunction

   // Four-phase transaction entered and left on a falling edge
   task automatic handshake_xfer(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                                 output reg_data_t rdata);
      int edges;
      check_equal("host_ack_o before host_req_i", host_ack, 1'b0);
      host_req   = 1'b1;
      host_wr    = wr;
      host_addr  = addr;
      host_wdata = wdata;
      edges      = 0;
      while (host_ack !== 1'b1) begin
         @(posedge clk);
         @(negedge clk);
         edges++;
         assert (edges <= ACK_WAIT_LIMIT) else begin
            abort_run("host_ack_o did not rise after host_req_i");
         end
      end
      check_equal("host_ack_o rise latency", edges, 3);
      rdata    = host_rdata;   // Valid while ack is high
      host_req = 1'b0;
      edges    = 0;
      while (host_ack !== 1'b0) begin
         @(posedge clk);
         @(negedge clk);
         edges++;
         assert (edges <= ACK_WAIT_LIMIT) else begin
            abort_run("host_ack_o stayed high after host_req_i fell");
         end
      end
      check_equal("host_ack_o fall latency", edges, 2);
   endtask

   task automatic host_write(input reg_addr_t addr, input reg_data_t wdata);
      reg_data_t unused;
      handshake_xfer(1'b1, addr, wdata, unused);
   endtask

   task automatic host_read(input reg_addr_t addr, output reg_data_t rdata);
      handshake_xfer(1'b0, addr, 8'h00, rdata);
   endtask

   task automatic expect_reg(input reg_addr_t addr, input reg_data_t exp_v, input string name);
      reg_data_t rd;
      host_read(addr, rd);
      check_equal(name, rd, exp_v);
   endtask

   task automatic reset_values();
      check_equal("host_ack_o", host_ack, 1'b0);
      check_equal("trigger_o", trigger, 1'b0);
      check_equal("target_npower_o", target_npower, 1'b0);
      check_equal("target_io_io", pins, 4'b0000);
      expect_reg(`CW_ADDR_CTRL, 8'h00, "ctrl register");
      expect_reg(`CW_ADDR_TRIGCNT, 8'h00, "trigger counter");
      for (int i = 0; i < `CW_NUM_IO; i++) begin
         expect_reg(chan_addr(i), 8'h00, $sformatf("channel %0d register", i));
      end
   endtask

   task automatic register_round_trip();
      reg_data_t wdata [`CW_NUM_IO];
      reg_data_t exp_v;
      reg_data_t w;
      reg_addr_t unmapped [5] = '{6'h02, 6'h05, 6'h0F, 6'h14, 6'h3F};
      for (int round = 0; round < 2; round++) begin
         for (int i = 0; i < `CW_NUM_IO; i++) begin
            wdata[i] = $random(seed);
            host_write(chan_addr(i), wdata[i]);
         end
         wait_cycles(3);   // Synchronizers settle
         for (int i = 0; i < `CW_NUM_IO; i++) begin
            exp_v = '0;
            exp_v[`CW_IO_INV_BIT:`CW_IO_OE_BIT] = wdata[i][`CW_IO_INV_BIT:`CW_IO_OE_BIT];
            // Driven pin shows the value bit and a floating one the pull-down
            exp_v[`CW_IO_PIN_BIT] = wdata[i][`CW_IO_OE_BIT] & wdata[i][`CW_IO_VAL_BIT];
            expect_reg(chan_addr(i), exp_v, $sformatf("channel %0d readback", i));
         end
      end
      for (int n = 0; n < 4; n++) begin
         w     = $random(seed);
         exp_v = '0;
         exp_v[`CW_CTRL_AND_BIT]    = w[`CW_CTRL_AND_BIT];
         exp_v[`CW_CTRL_PWROFF_BIT] = w[`CW_CTRL_PWROFF_BIT];
         host_write(`CW_ADDR_CTRL, w);
         expect_reg(`CW_ADDR_CTRL, exp_v, "ctrl readback");
      end
      host_write(`CW_ADDR_CTRL, 8'h00);
      host_write(6'h05, 8'hFF);   // Ignored write
      foreach (unmapped[k]) begin
         expect_reg(unmapped[k], 8'h00, $sformatf("unmapped 0x%0h", unmapped[k]));
      end
   endtask

   task automatic pin_drive_sense();
      reg_data_t cfg;
      reg_data_t exp_v;
      for (int i = 0; i < `CW_NUM_IO; i++) host_write(chan_addr(i), 8'h00);
      for (int i = 0; i < `CW_NUM_IO; i++) begin
         for (int v = 0; v < 2; v++) begin
            cfg = '0;
            cfg[`CW_IO_OE_BIT]  = 1'b1;
            cfg[`CW_IO_VAL_BIT] = v[0];
            host_write(chan_addr(i), cfg);
            wait_cycles(1);
            check_equal($sformatf("target_io_io[%0d]", i), pins[i], v);
            host_write(chan_addr(i), 8'h00);   // Release before the testbench drives
            drv_val[i] = v[0];
            drv_en[i]  = 1'b1;
            wait_cycles(4);
            exp_v = '0;
            exp_v[`CW_IO_PIN_BIT] = v[0];
            expect_reg(chan_addr(i), exp_v, $sformatf("channel %0d sensed pin", i));
            drv_en[i] = 1'b0;
         end
      end
   endtask

   task automatic trigger_combining();
      logic                  and_mode;
      logic [`CW_NUM_IO-1:0] en;
      logic [`CW_NUM_IO-1:0] inv;
      logic [`CW_NUM_IO-1:0] pat;
      reg_data_t             cfg;
      for (int r = 0; r < TRIG_ROUNDS; r++) begin
         and_mode = r[0];   // Alternate OR and AND
         en       = $random(seed);
         inv      = $random(seed);
         pat      = $random(seed);
         cfg      = '0;
         cfg[`CW_CTRL_AND_BIT] = and_mode;
         host_write(`CW_ADDR_CTRL, cfg);
         for (int i = 0; i < `CW_NUM_IO; i++) begin
            cfg = '0;   // OE stays clear so the testbench owns the pins
            cfg[`CW_IO_TEN_BIT] = en[i];
            cfg[`CW_IO_INV_BIT] = inv[i];
            host_write(chan_addr(i), cfg);
         end
         drv_val = pat;
         drv_en  = '1;
         wait_cycles(6);
         check_equal($sformatf("trigger_o round %0d", r), trigger,
                     trigger_rule(and_mode, en, inv, pat));
      end
      drv_en = '0;
   endtask

   task automatic counter_power_off();
      reg_data_t cfg;
      reg_data_t ctrl;
      host_write(`CW_ADDR_CTRL, 8'h00);
      for (int i = 0; i < `CW_NUM_IO; i++) host_write(chan_addr(i), 8'h00);
      drv_val = '0;
      drv_en  = 4'b0001;
      cfg     = '0;
      cfg[`CW_IO_TEN_BIT] = 1'b1;
      host_write(chan_addr(0), cfg);
      wait_cycles(6);
      host_write(`CW_ADDR_TRIGCNT, 8'h00);
      expect_reg(`CW_ADDR_TRIGCNT, 8'h00, "trigger counter after clear");
      for (int n = 0; n < TOGGLE_COUNT; n++) begin
         drv_val[0] = 1'b1;
         wait_cycles(5);
         drv_val[0] = 1'b0;
         wait_cycles(5);
      end
      expect_reg(`CW_ADDR_TRIGCNT, TOGGLE_COUNT % 256, "trigger counter");
      host_write(`CW_ADDR_TRIGCNT, 8'h5A);
      expect_reg(`CW_ADDR_TRIGCNT, 8'h00, "trigger counter after write");
      drv_en = '0;
      cfg    = '0;
      cfg[`CW_IO_OE_BIT]  = 1'b1;
      cfg[`CW_IO_VAL_BIT] = 1'b1;
      host_write(chan_addr(1), cfg);
      wait_cycles(1);
      check_equal("target_io_io[1] driven", pins[1], 1'b1);
      ctrl = '0;
      ctrl[`CW_CTRL_PWROFF_BIT] = 1'b1;
      host_write(`CW_ADDR_CTRL, ctrl);
      wait_cycles(3);
      check_equal("target_npower_o", target_npower, 1'b1);
      check_equal("target_io_io[1] powered off", pins[1], 1'b0);
      expect_reg(chan_addr(1), cfg, "channel 1 readback powered off");
      host_write(`CW_ADDR_CTRL, 8'h00);
      wait_cycles(1);
      check_equal("target_npower_o", target_npower, 1'b0);
      check_equal("target_io_io[1] powered on", pins[1], 1'b1);
   endtask

   initial begin
      rst_n      = 1'b0;
      host_req   = 1'b0;
      host_wr    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      drv_en     = '0;
      drv_val    = '0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      reset_values();
      register_round_trip();
      pin_drive_sense();
      trigger_combining();
      counter_power_off();
      $display("All tests passed");
      $finish;
   end

   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $fatal(1);
   end

endmodule

`default_nettype wire
